//--- Bender.yml
package:
  name: soc_interconnect

sources:
  # Packages first, then the modules that import them
  - files:
      - verilog/tcdm_pkg.sv
      - verilog/soc_mem_map_pkg.sv
      - verilog/tcdm_addr_decode.sv
      - verilog/l2_bank_arbiter.sv
      - verilog/tcdm_resp_router.sv
      - verilog/soc_interconnect.sv

  - target: simulation
    files:
      - sim/tb_soc_interconnect.sv

//--- sim/tb_soc_interconnect.sv
`timescale 1ns/1ps

module tb_soc_interconnect
    import tcdm_pkg::*;
    import soc_mem_map_pkg::*;
();

    localparam int NR_MASTERS      = 3;
    localparam int NR_BANKS        = 4;
    localparam int BANK_ADDR_WIDTH = 10;
    localparam int BANK_WORDS      = 2 ** BANK_ADDR_WIDTH;
    localparam int REGION_BYTES    = NR_BANKS * 4 * BANK_WORDS; // 16 KiB window
    localparam int PERIOD          = 40;
    localparam int TIMEOUT_CYCLES  = 20;                         // Grant wait limit
    localparam int CONFLICT_GRANTS = 45;

    logic                       clk;
    logic                       reset;
    logic [NR_MASTERS-1:0]      master_req;
    addr_t                      master_add     [NR_MASTERS];
    logic [NR_MASTERS-1:0]      master_wen;                      // 1 means read
    data_t                      master_wdata   [NR_MASTERS];
    be_t                        master_be      [NR_MASTERS];
    logic [NR_MASTERS-1:0]      master_gnt;
    logic [NR_MASTERS-1:0]      master_r_valid;
    data_t                      master_r_rdata [NR_MASTERS];
    resp_opc_t                  master_r_opc   [NR_MASTERS];
    logic [NR_BANKS-1:0]        bank_req;
    logic [BANK_ADDR_WIDTH-1:0] bank_add       [NR_BANKS];
    logic [NR_BANKS-1:0]        bank_wen;
    data_t                      bank_wdata     [NR_BANKS];
    be_t                        bank_be        [NR_BANKS];
    data_t                      bank_rdata     [NR_BANKS];

    data_t       bank_mem [NR_BANKS][BANK_WORDS]; // Bank contents
    logic [7:0]  ref_mem  [REGION_BYTES];         // Expected image with one byte per offset
    logic [31:0] rng_state;
    int          checks_done;

    soc_interconnect #(
        .NR_MASTERS      (NR_MASTERS),
        .NR_BANKS        (NR_BANKS),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) dut_i (
        .clk_i            (clk),
        .reset_i          (reset),
        .master_req_i     (master_req),
        .master_add_i     (master_add),
        .master_wen_i     (master_wen),
        .master_wdata_i   (master_wdata),
        .master_be_i      (master_be),
        .master_gnt_o     (master_gnt),
        .master_r_valid_o (master_r_valid),
        .master_r_rdata_o (master_r_rdata),
        .master_r_opc_o   (master_r_opc),
        .bank_req_o       (bank_req),
        .bank_add_o       (bank_add),
        .bank_wen_o       (bank_wen),
        .bank_wdata_o     (bank_wdata),
        .bank_be_o        (bank_be),
        .bank_rdata_i     (bank_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // L2 bank models
    ////////////////////

    // Zero wait state SRAM with read data one cycle after req
    always @(posedge clk) begin
        for (int b = 0; b < NR_BANKS; b++) begin
            if (bank_req[b] && bank_wen[b]) begin
                bank_rdata[b] <= bank_mem[b][bank_add[b]];
            end else if (bank_req[b]) begin
                for (int k = 0; k < 4; k++) begin
                    if (bank_be[b][k]) begin
                        bank_mem[b][bank_add[b]][8*k +: 8] = bank_wdata[b][8*k +: 8];
                    end
                end
            end
        end
    end

    ////////////////////
    // Model helpers
    ////////////////////

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13); // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Initial byte at a region offset built from every offset bit
    function automatic logic [7:0] fill_byte(int unsigned off);
        return 8'(off) ^ 8'(off >> 8) ^ 8'h5a;
    endfunction

    // Region offset seen by master m or -1 when the access must fail
    function automatic int model_offset(int m, addr_t addr);
        addr_t eff;
        eff = addr;
        if (m == 0 && addr[31:20] == FC_ALIAS_PREFIX) begin
            eff[31:20] = SOC_PREFIX; // FC data alias
        end
        if (eff < TCDM_START_ADDR || eff >= TCDM_START_ADDR + REGION_BYTES) begin
            return -1;
        end
        return int'(eff - TCDM_START_ADDR);
    endfunction

    function automatic data_t ref_word(int off);
        int base;
        base = off & ~3;
        return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
    endfunction

    function automatic void ref_write(int off, data_t wdata, be_t be);
        int base;
        base = off & ~3;
        for (int k = 0; k < 4; k++) begin
            if (be[k]) begin
                ref_mem[base + k] = wdata[8*k +: 8];
            end
        end
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks_done++;
        if (actual !== expected) begin
            stop_with_failure($sformatf("error %s: got 0x%08h, expected 0x%08h",
                                        name, actual, expected));
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    // One isolated request while the other masters stay idle
    task automatic single_access(input int m, input addr_t addr, input logic wen,
                                 input data_t wdata, input be_t be);
        int    off;
        int    bank;
        int    cycles;
        data_t exp_rdata;
        off    = model_offset(m, addr);
        bank   = (off >> 2) % NR_BANKS;  // Word interleaving
        cycles = 0;
        @(negedge clk);
        master_req[m]   = 1'b1;
        master_add[m]   = addr;
        master_wen[m]   = wen;
        master_wdata[m] = wdata;
        master_be[m]    = be;
        #(PERIOD / 4);
        while (!master_gnt[m]) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_with_failure($sformatf("master %0d was never granted", m));
            end
            @(negedge clk);
            #(PERIOD / 4);
        end
        check_value("master_gnt_o", master_gnt, 32'(1) << m);
        check_value("master_r_valid_o", master_r_valid[m], 1'b0);
        if (off < 0) begin
            check_value("bank_req_o", bank_req, '0); // Error slave touches no bank
        end else begin
            check_value("bank_req_o", bank_req, 32'(1) << bank);
            check_value("bank_add_o", bank_add[bank], (off >> 2) / NR_BANKS);
            check_value("bank_wen_o", bank_wen[bank], wen);
            exp_rdata = ref_word(off);
            if (!wen) begin
                ref_write(off, wdata, be);
            end
        end
        @(negedge clk);
        master_req[m] = 1'b0;
        #(PERIOD / 4);
        check_value("master_r_valid_o", master_r_valid[m], 1'b1);
        check_value("bank_req_o", bank_req, '0); // Bank touched in grant cycle only
        if (off < 0) begin
            check_value("master_r_opc_o", master_r_opc[m], RESP_OPC_ERR);
            check_value("master_r_rdata_o", master_r_rdata[m], '0);
        end else begin
            check_value("master_r_opc_o", master_r_opc[m], RESP_OPC_OK);
            if (wen) begin
                check_value("master_r_rdata_o", master_r_rdata[m], exp_rdata);
            end
        end
        @(negedge clk);
        #(PERIOD / 4);
        check_value("master_r_valid_o", master_r_valid[m], 1'b0); // One cycle pulse
    endtask

    task automatic load_bank_write(input int m, input int bank);
        int word;
        word            = next_rand() % BANK_WORDS;
        master_req[m]   = 1'b1;
        master_add[m]   = TCDM_START_ADDR + ((word * NR_BANKS + bank) * 4);
        master_wen[m]   = 1'b0;
        master_wdata[m] = next_rand();
        master_be[m]    = be_t'(next_rand());
    endtask

    // All masters hammer one bank with a new write after every grant
    task automatic bank_conflict(input int bank);
        int                    winner;
        int                    nr_gnt;
        int                    history [$];
        int                    written [$];
        logic [NR_MASTERS-1:0] prev_gnt;
        logic [NR_MASTERS-1:0] seen;
        prev_gnt = '0;
        for (int g = 0; g < CONFLICT_GRANTS; g++) begin
            @(negedge clk);
            for (int m = 0; m < NR_MASTERS; m++) begin
                if (g == 0 || prev_gnt[m]) begin
                    load_bank_write(m, bank);
                end
            end
            #(PERIOD / 4);
            check_value("master_r_valid_o", master_r_valid, prev_gnt);
            check_value("bank_req_o", bank_req, 32'(1) << bank);
            winner = -1;
            nr_gnt = 0;
            for (int m = 0; m < NR_MASTERS; m++) begin
                if (master_gnt[m]) begin
                    winner = m;
                    nr_gnt++;
                end
            end
            if (nr_gnt != 1) begin
                stop_with_failure($sformatf("bank %0d granted %0d masters", bank, nr_gnt));
            end
            ref_write(model_offset(winner, master_add[winner]), master_wdata[winner],
                      master_be[winner]);
            written.push_back(model_offset(winner, master_add[winner]));
            history.push_back(winner);
            // Every window of NR_MASTERS grants covers all masters
            if (history.size() >= NR_MASTERS) begin
                seen = '0;
                for (int i = history.size() - NR_MASTERS; i < history.size(); i++) begin
                    seen[history[i]] = 1'b1;
                end
                check_value("master_gnt_o window", seen, {NR_MASTERS{1'b1}});
            end
            prev_gnt = master_gnt;
        end
        @(negedge clk);
        master_req = '0;
        #(PERIOD / 4);
        check_value("master_r_valid_o", master_r_valid, prev_gnt);
        foreach (written[i]) begin
            single_access(next_rand() % NR_MASTERS, TCDM_START_ADDR + written[i], 1'b1,
                          '0, '0);
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        addr_t addr;
        int    off;
        rng_state   = 32'h1b88_7c3a;
        checks_done = 0;
        reset       = 1'b1;
        master_req  = '0;
        master_wen  = '0;
        for (int m = 0; m < NR_MASTERS; m++) begin
            master_add[m]   = '0;
            master_wdata[m] = '0;
            master_be[m]    = '0;
        end
        for (int b = 0; b < NR_BANKS; b++) begin
            bank_rdata[b] = '0;
            for (int w = 0; w < BANK_WORDS; w++) begin
                off            = (w * NR_BANKS + b) * 4;
                bank_mem[b][w] = {fill_byte(off + 3), fill_byte(off + 2),
                                  fill_byte(off + 1), fill_byte(off)};
            end
        end
        for (int i = 0; i < REGION_BYTES; i++) begin
            ref_mem[i] = fill_byte(i);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #(PERIOD / 4);
        check_value("master_gnt_o", master_gnt, '0);       // Idle after reset
        check_value("master_r_valid_o", master_r_valid, '0);
        check_value("bank_req_o", bank_req, '0);

        // Random writes each read back by a random master
        repeat (40) begin
            addr = TCDM_START_ADDR + (next_rand() % REGION_BYTES);
            single_access(next_rand() % NR_MASTERS, addr, 1'b0, next_rand(), be_t'(next_rand()));
            single_access(next_rand() % NR_MASTERS, addr, 1'b1, '0, '0);
        end
        repeat (20) begin
            addr = TCDM_START_ADDR + (next_rand() % REGION_BYTES);
            single_access(next_rand() % NR_MASTERS, addr, 1'b1, '0, '0);
        end

        // FC alias on master 0 only
        repeat (10) begin
            off = next_rand() % REGION_BYTES;
            single_access(0, {FC_ALIAS_PREFIX, 20'(off)}, 1'b0, next_rand(), 4'hf);
            single_access(1, TCDM_START_ADDR + off, 1'b1, '0, '0);
            single_access(0, {FC_ALIAS_PREFIX, 20'(off)}, 1'b1, '0, '0);
            single_access(1, {FC_ALIAS_PREFIX, 20'(off)}, 1'b1, '0, '0); // ERR
            single_access(2, {FC_ALIAS_PREFIX, 20'(off)}, 1'b0, next_rand(), 4'hf);
        end

        // Out of region edges first
        single_access(0, TCDM_START_ADDR - 4, 1'b1, '0, '0);
        single_access(1, TCDM_START_ADDR + REGION_BYTES, 1'b0, next_rand(), 4'hf);
        single_access(2, 32'hffff_fffc, 1'b1, '0, '0);
        single_access(0, {FC_ALIAS_PREFIX, 20'(REGION_BYTES)}, 1'b1, '0, '0);
        repeat (10) begin
            single_access(next_rand() % NR_MASTERS, next_rand(), next_rand() % 2,
                          next_rand(), be_t'(next_rand()));
        end

        bank_conflict(next_rand() % NR_BANKS);
        bank_conflict(next_rand() % NR_BANKS);

        if (checks_done > 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stop_with_failure("no checks were executed");
        end
    end

endmodule

//--- verilog.f
verilog/tcdm_pkg.sv
verilog/soc_mem_map_pkg.sv
verilog/tcdm_addr_decode.sv
verilog/l2_bank_arbiter.sv
verilog/tcdm_resp_router.sv
verilog/soc_interconnect.sv
sim/tb_soc_interconnect.sv

//--- verilog/l2_bank_arbiter.sv
`timescale 1ns/1ps

module l2_bank_arbiter
    import tcdm_pkg::*;
#(
    parameter int NR_MASTERS       = 3,
    parameter int BANK_ADDR_WIDTH  = 10,
    parameter int MASTER_IDX_WIDTH = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic [NR_MASTERS-1:0]       bank_sel_i,                     // Requests to this bank
    input  logic [NR_MASTERS-1:0]       master_wen_i,                   // 1 means read
    input  data_t                       master_wdata_i  [NR_MASTERS],
    input  be_t                         master_be_i     [NR_MASTERS],
    input  logic [BANK_ADDR_WIDTH-1:0]  bank_word_add_i [NR_MASTERS],
    output logic [NR_MASTERS-1:0]       grant_o,                        // One-hot, same cycle
    output logic                        bank_req_o,
    output logic [BANK_ADDR_WIDTH-1:0]  bank_add_o,
    output logic                        bank_wen_o,
    output data_t                       bank_wdata_o,
    output be_t                         bank_be_o,
    output logic                        resp_valid_o,                   // Bank data is back
    output logic [MASTER_IDX_WIDTH-1:0] resp_master_o                   // Who gets it
);

    logic [MASTER_IDX_WIDTH-1:0] rr_ptr_q;   // Highest priority master this cycle
    logic [MASTER_IDX_WIDTH-1:0] winner;
    logic                        found;      // Any request for this bank
    logic                        resp_valid_q;
    logic [MASTER_IDX_WIDTH-1:0] resp_master_q;

    ////////////////////
    // Round robin pick
    ////////////////////

    // Scan from the pointer, wrapping at NR_MASTERS
    always_comb begin
        int unsigned cand;
        winner = '0;
        found  = 1'b0;
        for (int i = 0; i < NR_MASTERS; i++) begin
            cand = rr_ptr_q + i;
            if (cand >= NR_MASTERS) begin
                cand = cand - NR_MASTERS; // Wrap around
            end
            if (!found && bank_sel_i[cand]) begin
                found  = 1'b1;
                winner = MASTER_IDX_WIDTH'(cand); // First requester after the pointer
            end
        end
    end

    always_comb begin
        grant_o = '0;
        if (found) begin
            grant_o[winner] = 1'b1;
        end
    end

    ////////////////////
    // Bank port mux
    ////////////////////

    assign bank_req_o   = found;                    // Banks never stall
    assign bank_add_o   = bank_word_add_i[winner];
    assign bank_wen_o   = master_wen_i[winner];
    assign bank_wdata_o = master_wdata_i[winner];
    assign bank_be_o    = master_be_i[winner];

    ////////////////////
    // State
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rr_ptr_q      <= '0;                    // Master 0 first after reset
            resp_valid_q  <= 1'b0;
            resp_master_q <= '0;
        end else begin
            resp_valid_q <= found;                  // Data returns next cycle
            if (found) begin
                resp_master_q <= winner;
                // Next search starts after the winner
                if (winner == MASTER_IDX_WIDTH'(NR_MASTERS - 1)) begin
                    rr_ptr_q <= '0;
                end else begin
                    rr_ptr_q <= winner + 1'b1;
                end
            end
        end
    end

    assign resp_valid_o  = resp_valid_q;
    assign resp_master_o = resp_master_q;

endmodule

//--- verilog/soc_interconnect.sv
`timescale 1ns/1ps

module soc_interconnect
    import tcdm_pkg::*;
    import soc_mem_map_pkg::*;
#(
    parameter int NR_MASTERS      = 3,  // FC data, FC instr, uDMA
    parameter int NR_BANKS        = 4,  // Interleaved L2 banks, power of two
    parameter int BANK_ADDR_WIDTH = 10  // log2 of words per bank
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    // Core side
    input  logic [NR_MASTERS-1:0]      master_req_i,
    input  addr_t                      master_add_i     [NR_MASTERS],
    input  logic [NR_MASTERS-1:0]      master_wen_i,                 // 1 means read
    input  data_t                      master_wdata_i   [NR_MASTERS],
    input  be_t                        master_be_i      [NR_MASTERS],
    output logic [NR_MASTERS-1:0]      master_gnt_o,
    output logic [NR_MASTERS-1:0]      master_r_valid_o,
    output data_t                      master_r_rdata_o [NR_MASTERS],
    output resp_opc_t                  master_r_opc_o   [NR_MASTERS],
    // L2 bank side
    output logic [NR_BANKS-1:0]        bank_req_o,
    output logic [BANK_ADDR_WIDTH-1:0] bank_add_o       [NR_BANKS],  // Word address
    output logic [NR_BANKS-1:0]        bank_wen_o,
    output data_t                      bank_wdata_o     [NR_BANKS],
    output be_t                        bank_be_o        [NR_BANKS],
    input  data_t                      bank_rdata_i     [NR_BANKS]   // One cycle after req
);

    localparam int MASTER_IDX_WIDTH = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;

    logic [NR_BANKS-1:0]         bank_sel      [NR_MASTERS]; // Decoder rows
    logic [BANK_ADDR_WIDTH-1:0]  bank_word_add [NR_MASTERS];
    logic [NR_MASTERS-1:0]       err_req;
    logic [NR_MASTERS-1:0]       bank_grant    [NR_BANKS];
    logic [NR_BANKS-1:0]         resp_valid;
    logic [MASTER_IDX_WIDTH-1:0] resp_master   [NR_BANKS];

    ////////////////////
    // Decode
    ////////////////////

    tcdm_addr_decode #(
        .NR_MASTERS      (NR_MASTERS),
        .NR_BANKS        (NR_BANKS),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) i_addr_decode (
        .master_req_i    (master_req_i),
        .master_add_i    (master_add_i),
        .bank_sel_o      (bank_sel),
        .bank_word_add_o (bank_word_add),
        .err_req_o       (err_req)
    );

    ////////////////////
    // Bank arbiters
    ////////////////////

    for (genvar b = 0; b < NR_BANKS; b++) begin : gen_bank
        logic [NR_MASTERS-1:0] sel_col; // This bank's column of the request matrix

        for (genvar m = 0; m < NR_MASTERS; m++) begin : gen_col
            assign sel_col[m] = bank_sel[m][b];
        end

        l2_bank_arbiter #(
            .NR_MASTERS       (NR_MASTERS),
            .BANK_ADDR_WIDTH  (BANK_ADDR_WIDTH),
            .MASTER_IDX_WIDTH (MASTER_IDX_WIDTH)
        ) i_bank_arbiter (
            .clk_i           (clk_i),
            .reset_i         (reset_i),
            .bank_sel_i      (sel_col),
            .master_wen_i    (master_wen_i),
            .master_wdata_i  (master_wdata_i),
            .master_be_i     (master_be_i),
            .bank_word_add_i (bank_word_add),
            .grant_o         (bank_grant[b]),
            .bank_req_o      (bank_req_o[b]),
            .bank_add_o      (bank_add_o[b]),
            .bank_wen_o      (bank_wen_o[b]),
            .bank_wdata_o    (bank_wdata_o[b]),
            .bank_be_o       (bank_be_o[b]),
            .resp_valid_o    (resp_valid[b]),
            .resp_master_o   (resp_master[b])
        );
    end

    ////////////////////
    // Responses
    ////////////////////

    tcdm_resp_router #(
        .NR_MASTERS       (NR_MASTERS),
        .NR_BANKS         (NR_BANKS),
        .MASTER_IDX_WIDTH (MASTER_IDX_WIDTH)
    ) i_resp_router (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .err_req_i        (err_req),
        .bank_grant_i     (bank_grant),
        .resp_valid_i     (resp_valid),
        .resp_master_i    (resp_master),
        .bank_rdata_i     (bank_rdata_i),
        .master_gnt_o     (master_gnt_o),
        .master_r_valid_o (master_r_valid_o),
        .master_r_rdata_o (master_r_rdata_o),
        .master_r_opc_o   (master_r_opc_o)
    );

endmodule

//--- verilog/soc_mem_map_pkg.sv
package soc_mem_map_pkg;

    ////////////////////
    // L2 region
    ////////////////////

    // Interleaved TCDM window, byte address
    localparam logic [31:0] TCDM_START_ADDR = 32'h1C00_0000;

    ////////////////////
    // Legacy alias
    ////////////////////

    // Width of the top address field that selects a 1 MiB block
    localparam int PREFIX_WIDTH = 12;

    // FC data port may reach L2 through the low block
    localparam logic [PREFIX_WIDTH-1:0] FC_ALIAS_PREFIX = 12'h000;

    // Block the alias is folded onto
    localparam logic [PREFIX_WIDTH-1:0] SOC_PREFIX = 12'h1C0;

    ////////////////////
    // Response codes
    ////////////////////

    typedef logic resp_opc_t; // r_opc sideband

    localparam resp_opc_t RESP_OPC_OK  = 1'b0; // Access completed
    localparam resp_opc_t RESP_OPC_ERR = 1'b1; // No slave at this address

endpackage

//--- verilog/tcdm_addr_decode.sv
`timescale 1ns/1ps

module tcdm_addr_decode
    import tcdm_pkg::*;
    import soc_mem_map_pkg::*;
#(
    parameter int NR_MASTERS      = 3,
    parameter int NR_BANKS        = 4,  // Power of two
    parameter int BANK_ADDR_WIDTH = 10  // log2 of words per bank
) (
    input  logic [NR_MASTERS-1:0]      master_req_i,
    input  addr_t                      master_add_i    [NR_MASTERS],
    output logic [NR_BANKS-1:0]        bank_sel_o      [NR_MASTERS], // One-hot bank request
    output logic [BANK_ADDR_WIDTH-1:0] bank_word_add_o [NR_MASTERS], // Word inside the bank
    output logic [NR_MASTERS-1:0]      err_req_o                     // Request outside L2
);

    ////////////////////
    // Address split
    ////////////////////

    localparam int BYTE_OFF_WIDTH = $clog2(BE_WIDTH);  // Byte lane bits, ignored
    localparam int BANK_SEL_WIDTH = $clog2(NR_BANKS);  // Bank index bits
    localparam int BANK_IDX_LSB   = BYTE_OFF_WIDTH;
    localparam int WORD_LSB       = BYTE_OFF_WIDTH + BANK_SEL_WIDTH;

    // Whole interleaved window in bytes
    localparam addr_t REGION_SIZE = addr_t'(NR_BANKS * BE_WIDTH * (2 ** BANK_ADDR_WIDTH));

    addr_t                     remap_add [NR_MASTERS]; // After alias folding
    addr_t                     offset    [NR_MASTERS]; // Relative to region base
    logic [NR_MASTERS-1:0]     in_region;
    logic [BANK_SEL_WIDTH-1:0] bank_idx  [NR_MASTERS];

    for (genvar m = 0; m < NR_MASTERS; m++) begin : gen_master

        // Only the FC data port keeps the legacy alias
        if (m == 0) begin : gen_fc_remap
            always_comb begin
                remap_add[m] = master_add_i[m];
                if (master_add_i[m][ADDR_WIDTH-1 -: PREFIX_WIDTH] == FC_ALIAS_PREFIX) begin
                    remap_add[m][ADDR_WIDTH-1 -: PREFIX_WIDTH] = SOC_PREFIX; // 0x000 -> 0x1C0
                end
            end
        end else begin : gen_no_remap
            assign remap_add[m] = master_add_i[m]; // Other masters see the raw map
        end

        // Below the base wraps to a huge offset, so one compare covers both ends
        assign offset[m]    = remap_add[m] - TCDM_START_ADDR;
        assign in_region[m] = (offset[m] < REGION_SIZE);

        // Word interleaving across banks
        assign bank_idx[m]        = offset[m][BANK_IDX_LSB +: BANK_SEL_WIDTH];
        assign bank_word_add_o[m] = offset[m][WORD_LSB +: BANK_ADDR_WIDTH];

        always_comb begin
            bank_sel_o[m] = '0;                       // Idle or error, no bank
            if (master_req_i[m] && in_region[m]) begin
                bank_sel_o[m][bank_idx[m]] = 1'b1;    // Target bank only
            end
        end

        // Out of region, answered by the router
        assign err_req_o[m] = master_req_i[m] & ~in_region[m];

    end

endmodule

//--- verilog/tcdm_pkg.sv
package tcdm_pkg;

    ////////////////////
    // Bus widths
    ////////////////////

    // All SoC addresses are 32 bit
    localparam int ADDR_WIDTH = 32;

    // One word per beat
    localparam int DATA_WIDTH = 32;

    // One strobe per byte lane
    localparam int BE_WIDTH = DATA_WIDTH / 8;

    ////////////////////
    // Payload types
    ////////////////////

    typedef logic [ADDR_WIDTH-1:0] addr_t; // Byte address
    typedef logic [DATA_WIDTH-1:0] data_t; // Read or write word
    typedef logic [BE_WIDTH-1:0]   be_t;   // Byte enables, bit i is lane i

endpackage

//--- verilog/tcdm_resp_router.sv
`timescale 1ns/1ps

module tcdm_resp_router
    import tcdm_pkg::*;
    import soc_mem_map_pkg::*;
#(
    parameter int NR_MASTERS       = 3,
    parameter int NR_BANKS         = 4,
    parameter int MASTER_IDX_WIDTH = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic [NR_MASTERS-1:0]       err_req_i,                  // Granted at once
    input  logic [NR_MASTERS-1:0]       bank_grant_i  [NR_BANKS],   // Per bank one-hot
    input  logic [NR_BANKS-1:0]         resp_valid_i,
    input  logic [MASTER_IDX_WIDTH-1:0] resp_master_i [NR_BANKS],
    input  data_t                       bank_rdata_i  [NR_BANKS],
    output logic [NR_MASTERS-1:0]       master_gnt_o,
    output logic [NR_MASTERS-1:0]       master_r_valid_o,
    output data_t                       master_r_rdata_o [NR_MASTERS],
    output resp_opc_t                   master_r_opc_o   [NR_MASTERS]
);

    logic [NR_MASTERS-1:0] err_q; // Error response pending

    ////////////////////
    // Grant merge
    ////////////////////

    // A master targets one bank or the error slave, never both
    always_comb begin
        master_gnt_o = err_req_i;
        for (int b = 0; b < NR_BANKS; b++) begin
            master_gnt_o = master_gnt_o | bank_grant_i[b];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            err_q <= '0;
        end else begin
            err_q <= err_req_i; // Answer one cycle later like a bank
        end
    end

    ////////////////////
    // Response steer
    ////////////////////

    always_comb begin
        for (int m = 0; m < NR_MASTERS; m++) begin
            master_r_valid_o[m] = err_q[m];
            master_r_rdata_o[m] = '0;                       // Zero on error
            master_r_opc_o[m]   = err_q[m] ? RESP_OPC_ERR : RESP_OPC_OK;
            // At most one bank answers a given master per cycle
            for (int b = 0; b < NR_BANKS; b++) begin
                if (resp_valid_i[b] && (resp_master_i[b] == MASTER_IDX_WIDTH'(m))) begin
                    master_r_valid_o[m] = 1'b1;
                    master_r_rdata_o[m] = bank_rdata_i[b];  // Don't care on writes
                end
            end
        end
    end

endmodule
